//--- dv/core_tb.sv
`include "core_macros.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ram_words = 16;
    localparam int timeout_cycles = 2000;
    // closing beq x0, x0, 0
    localparam logic [`XLEN-1:0] end_pc = 32'h0000_007c;

    logic             clk = 1'b0;
    logic             arst_n;
    logic [`XLEN-1:0] iaddr;
    logic [`XLEN-1:0] idata;
    logic [`XLEN-1:0] daddr;
    logic [`XLEN-1:0] dwdata;
    logic [`XLEN-1:0] drdata;
    logic             dreq;
    logic             dwrite;
    logic             dready_n;
    logic [`XLEN-1:0] exp_ram [ram_words];
    logic [`XLEN-1:0] held_addr;
    bit               held;
    bit               reached;
    int               mismatches;
    int               other_errors;

    always #2 clk = ~clk;

    core i_dut (
        .clk(clk), .arst_n(arst_n), .idata(idata), .drdata(drdata), .dready_n(dready_n),
        .iaddr(iaddr), .daddr(daddr), .dwdata(dwdata), .dreq(dreq), .dwrite(dwrite)
    );

    tb_memory i_mem (
        .clk(clk), .iaddr(iaddr), .idata(idata), .daddr(daddr), .dwdata(dwdata),
        .drdata(drdata), .dreq(dreq), .dwrite(dwrite), .dready_n(dready_n)
    );

    // ISA-level model of the same program
    function automatic void ref_run();
        logic [31:0] x [32];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] insn;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] wd;
        logic [2:0]  f3;
        bit          wr;
        for (int r = 0; r < 32; r++) begin
            x[r] = '0;
        end
        for (int w = 0; w < ram_words; w++) begin
            exp_ram[w] = i_mem.ram[w];
        end
        pc = `RESET_PC;
        for (int step = 0; step < 1000 && pc != end_pc; step++) begin
            insn    = i_mem.rom[pc[7:2]];
            f3      = insn[14:12];
            a       = x[insn[19:15]];
            b       = x[insn[24:20]];
            imm_i   = {{20{insn[31]}}, insn[31:20]};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            wd      = '0;
            case (insn[6:0])
                7'b0110011: begin
                    case ({insn[31:25], f3})
                        10'b0000000_000: wd = a + b;
                        10'b0100000_000: wd = a - b;
                        10'b0000000_010: wd = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        10'b0000000_100: wd = a ^ b;
                        10'b0000000_110: wd = a | b;
                        10'b0000000_111: wd = a & b;
                        default:         wr = 1'b0;
                    endcase
                end
                7'b0010011: begin
                    wr = (f3 == 3'b000);
                    wd = a + imm_i;
                end
                7'b0110111: wd = {insn[31:12], 12'b0};
                7'b0000011: begin
                    addr = a + imm_i;
                    wr   = (f3 == 3'b010);
                    wd   = exp_ram[addr[5:2]];
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = a + {{20{insn[31]}}, insn[31:25], insn[11:7]};
                    if (f3 == 3'b010) begin
                        exp_ram[addr[5:2]] = b;
                    end
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                        next_pc = pc + {{19{insn[31]}}, insn[31], insn[7], insn[30:25],
                                        insn[11:8], 1'b0};
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && insn[11:7] != 5'd0) begin
                x[insn[11:7]] = wd;
            end
            pc = next_pc;
        end
    endfunction

    task automatic wait_pc(input logic [`XLEN-1:0] target, input bit at, output bit ok);
        ok = 1'b0;
        for (int n = 0; n < timeout_cycles && !ok; n++) begin
            @(negedge clk);
            ok = ((iaddr === target) == at);
        end
        if (!ok) begin
            $display("program never reached its end");
            other_errors++;
        end
    endtask

    task automatic compare_ram();
        for (int i = 0; i < ram_words; i++) begin
            assert (i_mem.ram[i] === exp_ram[i]) else begin
                $display("Mismatch at %0t: ram[%0d] got %h expected %h",
                         $time, i, i_mem.ram[i], exp_ram[i]);
                mismatches++;
            end
        end
    endtask

    // bus quiet in reset and address held through wait states
    always @(negedge clk) begin
        if (!arst_n) begin
            assert (dreq === 1'b0) else begin
                $display("Mismatch at %0t: dreq got %b expected 0", $time, dreq);
                mismatches++;
            end
            assert (dwrite === 1'b0) else begin
                $display("Mismatch at %0t: dwrite got %b expected 0", $time, dwrite);
                mismatches++;
            end
        end else if (held) begin
            assert (daddr === held_addr) else begin
                $display("Mismatch at %0t: daddr got %h expected %h", $time, daddr, held_addr);
                mismatches++;
            end
        end
        held      = arst_n && dreq && dready_n;
        held_addr = daddr;
    end

    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        ref_run();
        #0.5;
        arst_n = 1'b1;
        #0.5;
        assert (iaddr === `RESET_PC) else begin
            $display("Mismatch at %0t: iaddr got %h expected %h", $time, iaddr, `RESET_PC);
            mismatches++;
        end
        // first arrival and one trip round the closing loop drain the pipeline
        wait_pc(end_pc, 1'b1, reached);
        if (reached) begin
            wait_pc(end_pc, 1'b0, reached);
        end
        if (reached) begin
            wait_pc(end_pc, 1'b1, reached);
        end
        if (reached) begin
            compare_ram();
        end
        $display("mismatches: %0d, other errors: %0d", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- dv/tb_memory.sv
`include "core_macros.svh"

module tb_memory (
    input  logic             clk,
    input  logic [`XLEN-1:0] iaddr,
    output logic [`XLEN-1:0] idata,
    input  logic [`XLEN-1:0] daddr,
    input  logic [`XLEN-1:0] dwdata,
    output logic [`XLEN-1:0] drdata,
    input  logic             dreq,
    input  logic             dwrite,
    output logic             dready_n
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int rom_words = 64;
    localparam int ram_words = 16;
    localparam int op_imm = 'h13;
    localparam int op_load = 'h03;

    logic [`XLEN-1:0] rom [rom_words];
    logic [`XLEN-1:0] ram [ram_words];
    integer           seed = 32'hbdc4cb8a;
    int               wait_left;
    bit               pending;
    bit               done;

    assign idata  = rom[iaddr[7:2]];
    assign drdata = ram[daddr[5:2]];

    function automatic logic [31:0] r_insn(input int f7, input int f3, input int rd,
                                           input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] i_insn(input int opc, input int f3, input int rd,
                                           input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
    endfunction

    function automatic logic [31:0] s_insn(input int rs2, input int rs1, input int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] b_insn(input int f3, input int rs1, input int rs2,
                                           input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
                7'b1100011};
    endfunction

    initial begin
        dready_n  = 1'b1;
        wait_left = 0;
        for (int i = 0; i < rom_words; i++) begin
            rom[i] = `NOP_INSN;
        end
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = (i + 1) * 32'h9e37_79b9;
        end
        rom[0]  = i_insn(op_imm, 0, 1, 0, 5);
        rom[1]  = i_insn(op_imm, 0, 2, 1, 7);
        rom[2]  = r_insn(0, 0, 3, 1, 2);
        rom[3]  = r_insn(32, 0, 4, 3, 1);
        // lui x5, 0x12345
        rom[4]  = {20'h12345, 5'd5, 7'b0110111};
        rom[5]  = r_insn(0, 4, 6, 5, 4);
        rom[6]  = r_insn(0, 6, 7, 6, 3);
        rom[7]  = r_insn(0, 7, 8, 7, 5);
        rom[8]  = r_insn(0, 2, 9, 4, 3);
        rom[9]  = s_insn(6, 0, 0);
        rom[10] = s_insn(8, 0, 4);
        rom[11] = s_insn(9, 0, 8);
        // load then immediate use
        rom[12] = i_insn(op_load, 2, 10, 0, 12);
        rom[13] = r_insn(0, 0, 11, 10, 7);
        rom[14] = s_insn(11, 0, 16);
        // taken beq skips two
        rom[15] = b_insn(0, 1, 1, 12);
        rom[16] = i_insn(op_imm, 0, 12, 0, 99);
        rom[17] = i_insn(op_imm, 0, 13, 0, 98);
        rom[18] = b_insn(1, 1, 2, 8);
        rom[19] = i_insn(op_imm, 0, 12, 12, 1);
        // not-taken beq keeps the next one
        rom[20] = b_insn(0, 1, 2, 8);
        rom[21] = i_insn(op_imm, 0, 13, 13, 3);
        rom[22] = b_insn(1, 1, 1, 8);
        rom[23] = i_insn(op_imm, 0, 12, 12, 4);
        // xori is outside the subset
        rom[24] = i_insn(op_imm, 4, 12, 12, 255);
        rom[25] = s_insn(12, 0, 20);
        rom[26] = s_insn(13, 0, 24);
        rom[27] = i_insn(op_load, 2, 14, 0, 28);
        rom[28] = s_insn(14, 0, 32);
        rom[29] = r_insn(32, 0, 15, 14, 11);
        rom[30] = s_insn(15, 0, 36);
        rom[31] = b_insn(0, 0, 0, 0);
    end

    // access completes on the edge that sees dready_n low
    always @(posedge clk) begin
        done = dreq && !dready_n;
        if (done && dwrite) begin
            ram[daddr[5:2]] = dwdata;
        end
        #0.5;
        if (!dreq) begin
            pending  = 1'b0;
            dready_n = 1'b1;
        end else if (!pending || done) begin
            pending   = 1'b1;
            wait_left = $unsigned($random(seed)) % 4;
            dready_n  = (wait_left != 0);
        end else begin
            wait_left = wait_left - 1;
            dready_n  = (wait_left != 0);
        end
    end

endmodule

//--- hdl/core.sv
`include "core_macros.svh"

module core (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] idata,
    input  logic [`XLEN-1:0] drdata,
    input  logic             dready_n,
    output logic [`XLEN-1:0] iaddr,
    output logic [`XLEN-1:0] daddr,
    output logic [`XLEN-1:0] dwdata,
    output logic             dreq,
    output logic             dwrite
);
    import core_pkg::*;

    logic [`XLEN-1:0] if_insn;
    logic [`XLEN-1:0] if_pc;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [`XLEN-1:0] rdata1;
    logic [`XLEN-1:0] rdata2;
    ctrl_t            ex_ctrl;
    logic [`XLEN-1:0] ex_a;
    logic [`XLEN-1:0] ex_b;
    logic [`XLEN-1:0] ex_imm;
    logic [`XLEN-1:0] ex_pc;
    logic [4:0]       ex_rs1;
    logic [4:0]       ex_rs2;
    logic [4:0]       ex_rd;
    logic             redirect_taken;
    logic [`XLEN-1:0] redirect_target;
    logic [4:0]       wb_rd;
    logic [`XLEN-1:0] wb_data;
    logic             wb_we;

    ex_mem_if    i_exm ();
    pipe_ctrl_if i_ctrl ();

    fetch i_fetch (
        .clk(clk), .arst_n(arst_n), .idata(idata),
        .redirect_taken(redirect_taken), .redirect_target(redirect_target),
        .ctrl(i_ctrl.stage),
        .iaddr(iaddr), .if_insn(if_insn), .if_pc(if_pc)
    );

    regfile i_regfile (
        .clk(clk), .arst_n(arst_n), .rs1(rs1), .rs2(rs2),
        .wb_rd(wb_rd), .wb_data(wb_data), .wb_we(wb_we),
        .rdata1(rdata1), .rdata2(rdata2)
    );

    decode i_decode (
        .clk(clk), .arst_n(arst_n), .if_insn(if_insn), .if_pc(if_pc),
        .rdata1(rdata1), .rdata2(rdata2), .ctrl(i_ctrl.stage),
        .rs1(rs1), .rs2(rs2), .ex_ctrl(ex_ctrl), .ex_a(ex_a), .ex_b(ex_b),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd)
    );

    execute i_execute (
        .clk(clk), .arst_n(arst_n), .ex_ctrl(ex_ctrl), .ex_a(ex_a), .ex_b(ex_b),
        .ex_imm(ex_imm), .ex_pc(ex_pc), .ex_rd(ex_rd), .wb_data(wb_data),
        .ctrl(i_ctrl.stage), .exm(i_exm.src),
        .redirect_taken(redirect_taken), .redirect_target(redirect_target)
    );

    mem_access i_mem_access (
        .clk(clk), .arst_n(arst_n), .drdata(drdata), .dready_n(dready_n),
        .exm(i_exm.dst), .ctrl(i_ctrl.stage),
        .daddr(daddr), .dwdata(dwdata), .dreq(dreq), .dwrite(dwrite),
        .wb_rd(wb_rd), .wb_data(wb_data), .wb_we(wb_we)
    );

    hazard_unit i_hazard_unit (
        .if_insn(if_insn), .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .ex_rd(ex_rd),
        .ex_mem_read(ex_ctrl.mem_read), .redirect_taken(redirect_taken),
        .wb_rd(wb_rd), .wb_we(wb_we), .dreq(dreq), .dready_n(dready_n),
        .exm(i_exm.mon), .ctrl(i_ctrl.ctrl)
    );

endmodule

//--- hdl/core_ifs.sv
`include "core_macros.svh"

interface ex_mem_if;
    import core_pkg::*;

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] store_data;
    logic [4:0]       rd;
    ctrl_t            ctrl;

    modport src (output alu_result, store_data, rd, ctrl);
    modport dst (input alu_result, store_data, rd, ctrl);
    // hazard unit only needs the destination
    modport mon (input rd, ctrl);
endinterface

interface pipe_ctrl_if;
    import core_pkg::*;

    logic     hold_front;
    logic     bubble_ex;
    logic     flush_front;
    logic     mem_wait;
    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    modport ctrl (output hold_front, bubble_ex, flush_front, mem_wait, fwd_a, fwd_b);
    modport stage (input hold_front, bubble_ex, flush_front, mem_wait, fwd_a, fwd_b);
endinterface

//--- hdl/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define NOP_INSN 32'h0000_0013

`endif

//--- hdl/core_pkg.sv
package core_pkg;

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_XOR    = 3'd4,
        ALU_SLT    = 3'd5,
        ALU_PASS_B = 3'd6
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_NONE     = 2'd0,
        FWD_FROM_MEM = 2'd1,
        FWD_FROM_WB  = 2'd2
    } fwd_sel_e;

    // all zero is a bubble
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    reg_write;
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
    } ctrl_t;

endpackage

//--- hdl/decode.sv
`include "core_macros.svh"

module decode (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] if_insn,
    input  logic [`XLEN-1:0] if_pc,
    input  logic [`XLEN-1:0] rdata1,
    input  logic [`XLEN-1:0] rdata2,
    pipe_ctrl_if.stage       ctrl,
    output logic [4:0]       rs1,
    output logic [4:0]       rs2,
    output core_pkg::ctrl_t  ex_ctrl,
    output logic [`XLEN-1:0] ex_a,
    output logic [`XLEN-1:0] ex_b,
    output logic [`XLEN-1:0] ex_imm,
    output logic [`XLEN-1:0] ex_pc,
    output logic [4:0]       ex_rs1,
    output logic [4:0]       ex_rs2,
    output logic [4:0]       ex_rd
);
    import core_pkg::*;

    opcode_e          opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic             op_legal;
    ctrl_t            dec;
    logic [`XLEN-1:0] imm;

    assign rs1    = if_insn[19:15];
    assign rs2    = if_insn[24:20];
    assign opcode = opcode_e'(if_insn[6:0]);
    assign funct3 = if_insn[14:12];
    assign funct7 = if_insn[31:25];
    // only SUB may set funct7
    assign op_legal = (funct7 == 7'b0) || (funct3 == 3'b000 && funct7 == 7'b0100000);

    always_comb begin
        dec = '0;
        imm = {{20{if_insn[31]}}, if_insn[31:20]};
        case (opcode)
            OPC_OP: begin
                dec.reg_write = op_legal;
                case (funct3)
                    3'b000:  dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    default: dec.reg_write = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                dec.alu_op    = ALU_PASS_B;
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                imm = {if_insn[31:12], 12'b0};
            end
            OPC_LOAD: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = (funct3 == 3'b010);
                dec.mem_read  = (funct3 == 3'b010);
            end
            OPC_STORE: begin
                dec.use_imm   = 1'b1;
                dec.mem_write = (funct3 == 3'b010);
                imm = {{20{if_insn[31]}}, if_insn[31:25], if_insn[11:7]};
            end
            OPC_BRANCH: begin
                dec.is_branch = (funct3[2:1] == 2'b00);
                dec.branch_ne = funct3[0];
                imm = {{19{if_insn[31]}}, if_insn[31], if_insn[7],
                       if_insn[30:25], if_insn[11:8], 1'b0};
            end
            default: dec = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_ctrl <= '0;
            ex_rs1  <= '0;
            ex_rs2  <= '0;
            ex_rd   <= '0;
        end else if (!ctrl.mem_wait) begin
            if (ctrl.flush_front || ctrl.bubble_ex) begin
                ex_ctrl <= '0;
                ex_rs1  <= '0;
                ex_rs2  <= '0;
                ex_rd   <= '0;
            end else begin
                ex_ctrl <= dec;
                ex_rs1  <= rs1;
                ex_rs2  <= rs2;
                ex_rd   <= if_insn[11:7];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mem_wait) begin
            ex_a   <= rdata1;
            ex_b   <= rdata2;
            ex_imm <= imm;
            ex_pc  <= if_pc;
        end
    end

endmodule

//--- hdl/execute.sv
`include "core_macros.svh"

module execute (
    input  logic             clk,
    input  logic             arst_n,
    input  core_pkg::ctrl_t  ex_ctrl,
    input  logic [`XLEN-1:0] ex_a,
    input  logic [`XLEN-1:0] ex_b,
    input  logic [`XLEN-1:0] ex_imm,
    input  logic [`XLEN-1:0] ex_pc,
    input  logic [4:0]       ex_rd,
    input  logic [`XLEN-1:0] wb_data,
    pipe_ctrl_if.stage       ctrl,
    ex_mem_if.src            exm,
    output logic             redirect_taken,
    output logic [`XLEN-1:0] redirect_target
);
    import core_pkg::*;

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_b;
    logic [`XLEN-1:0] result;

    function automatic logic [`XLEN-1:0] pick(input fwd_sel_e         sel,
                                              input logic [`XLEN-1:0] reg_val,
                                              input logic [`XLEN-1:0] mem_val,
                                              input logic [`XLEN-1:0] wb_val);
        case (sel)
            FWD_FROM_MEM: return mem_val;
            FWD_FROM_WB:  return wb_val;
            default:      return reg_val;
        endcase
    endfunction

    assign op_a  = pick(ctrl.fwd_a, ex_a, exm.alu_result, wb_data);
    assign op_b  = pick(ctrl.fwd_b, ex_b, exm.alu_result, wb_data);
    assign alu_b = ex_ctrl.use_imm ? ex_imm : op_b;

    always_comb begin
        case (ex_ctrl.alu_op)
            ALU_SUB:    result = op_a - alu_b;
            ALU_AND:    result = op_a & alu_b;
            ALU_OR:     result = op_a | alu_b;
            ALU_XOR:    result = op_a ^ alu_b;
            ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            ALU_PASS_B: result = alu_b;
            default:    result = op_a + alu_b;
        endcase
    end

    // beq and bne resolve here
    assign redirect_taken  = ex_ctrl.is_branch & ((op_a == op_b) ^ ex_ctrl.branch_ne);
    assign redirect_target = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exm.ctrl <= '0;
            exm.rd   <= '0;
        end else if (!ctrl.mem_wait) begin
            exm.ctrl <= ex_ctrl;
            exm.rd   <= ex_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mem_wait) begin
            exm.alu_result <= result;
            exm.store_data <= op_b;
        end
    end

endmodule

//--- hdl/fetch.sv
`include "core_macros.svh"

module fetch (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] idata,
    input  logic             redirect_taken,
    input  logic [`XLEN-1:0] redirect_target,
    pipe_ctrl_if.stage       ctrl,
    output logic [`XLEN-1:0] iaddr,
    output logic [`XLEN-1:0] if_insn,
    output logic [`XLEN-1:0] if_pc
);

    logic [`XLEN-1:0] pc;

    assign iaddr = pc;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc      <= `RESET_PC;
            if_insn <= `NOP_INSN;
        end else if (!ctrl.mem_wait) begin
            if (redirect_taken) begin
                pc <= redirect_target;
            end else if (!ctrl.hold_front) begin
                pc <= pc + `XLEN'd4;
            end
            // wrong-path fetch is dropped
            if (ctrl.flush_front) begin
                if_insn <= `NOP_INSN;
            end else if (!ctrl.hold_front) begin
                if_insn <= idata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mem_wait && !ctrl.hold_front) begin
            if_pc <= pc;
        end
    end

endmodule

//--- hdl/hazard_unit.sv
`include "core_macros.svh"

module hazard_unit (
    input  logic [`XLEN-1:0] if_insn,
    input  logic [4:0]       ex_rs1,
    input  logic [4:0]       ex_rs2,
    input  logic [4:0]       ex_rd,
    input  logic             ex_mem_read,
    input  logic             redirect_taken,
    input  logic [4:0]       wb_rd,
    input  logic             wb_we,
    input  logic             dreq,
    input  logic             dready_n,
    ex_mem_if.mon            exm,
    pipe_ctrl_if.ctrl        ctrl
);
    import core_pkg::*;

    logic load_use;

    function automatic fwd_sel_e fwd_for(input logic [4:0] src,
                                         input logic [4:0] mem_rd,
                                         input logic       mem_we,
                                         input logic [4:0] last_rd,
                                         input logic       last_we);
        if (src == 5'd0) begin
            return FWD_NONE;
        end
        // younger result wins
        if (mem_we && mem_rd == src) begin
            return FWD_FROM_MEM;
        end
        if (last_we && last_rd == src) begin
            return FWD_FROM_WB;
        end
        return FWD_NONE;
    endfunction

    // rs fields compared whatever the format
    assign load_use = ex_mem_read && ex_rd != 5'd0 &&
                      (ex_rd == if_insn[19:15] || ex_rd == if_insn[24:20]);

    assign ctrl.hold_front  = load_use;
    assign ctrl.bubble_ex   = load_use;
    assign ctrl.flush_front = redirect_taken;
    assign ctrl.mem_wait    = dreq & dready_n;

    assign ctrl.fwd_a = fwd_for(ex_rs1, exm.rd, exm.ctrl.reg_write, wb_rd, wb_we);
    assign ctrl.fwd_b = fwd_for(ex_rs2, exm.rd, exm.ctrl.reg_write, wb_rd, wb_we);

endmodule

//--- hdl/mem_access.sv
`include "core_macros.svh"

module mem_access (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [`XLEN-1:0] drdata,
    input  logic             dready_n,
    ex_mem_if.dst            exm,
    pipe_ctrl_if.stage       ctrl,
    output logic [`XLEN-1:0] daddr,
    output logic [`XLEN-1:0] dwdata,
    output logic             dreq,
    output logic             dwrite,
    output logic [4:0]       wb_rd,
    output logic [`XLEN-1:0] wb_data,
    output logic             wb_we
);

    logic [`XLEN-1:0] result;

    // bus levels follow EX/MEM while it is held
    assign daddr  = exm.alu_result;
    assign dwdata = exm.store_data;
    assign dreq   = exm.ctrl.mem_read | exm.ctrl.mem_write;
    assign dwrite = exm.ctrl.mem_write;

    // drdata only counts on the edge with dready_n low
    assign result = (exm.ctrl.mem_read && !dready_n) ? drdata : exm.alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_rd <= '0;
            wb_we <= 1'b0;
        end else if (!ctrl.mem_wait) begin
            wb_rd <= exm.rd;
            wb_we <= exm.ctrl.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.mem_wait) begin
            wb_data <= result;
        end
    end

endmodule

//--- hdl/regfile.sv
`include "core_macros.svh"

module regfile (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [4:0]       rs1,
    input  logic [4:0]       rs2,
    input  logic [4:0]       wb_rd,
    input  logic [`XLEN-1:0] wb_data,
    input  logic             wb_we,
    output logic [`XLEN-1:0] rdata1,
    output logic [`XLEN-1:0] rdata2
);

    logic [`XLEN-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write-first so WB and ID can overlap
    assign rdata1 = (rs1 == 5'd0) ? '0 :
                    (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rdata2 = (rs2 == 5'd0) ? '0 :
                    (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

endmodule

//--- src.f
+incdir+hdl
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/fetch.sv
hdl/regfile.sv
hdl/decode.sv
hdl/execute.sv
hdl/mem_access.sv
hdl/hazard_unit.sv
hdl/core.sv
dv/tb_memory.sv
dv/core_tb.sv
